/* addr_translate.sv */
`timescale 1ns/10ps
`default_nettype none

`include "loongarch_fetch_macros.svh"

module addr_translate import fetch_pkg::*; (
    input  wire logic [31:0]             vaddr,
    input  wire logic                    direct_mode,
    input  wire logic [1:0]              plv,
    input  dmw_cfg_t                     dmw0,
    input  dmw_cfg_t                     dmw1,
    // tlb search
    output logic [18:0]                  vppn,
    output logic                         va_bit12,
    input  tlb_result_t                  tlb_res,
    // result
    output logic [31:0]                  paddr,
    output logic [`TLB_ERRLEN-1:0]       tlb_exc
);

    logic        dmw0_hit;
    logic        dmw1_hit;
    logic        tlb_used;
    logic [31:0] tlb_paddr;

    assign vppn     = vaddr[31:13];
    assign va_bit12 = vaddr[12];

    // window hits on segment match and an enabled privilege level
    assign dmw0_hit = (vaddr[31:29] == dmw0.vseg) &&
                      ((plv == 2'd0 && dmw0.plv0) || (plv == 2'd3 && dmw0.plv3));
    assign dmw1_hit = (vaddr[31:29] == dmw1.vseg) &&
                      ((plv == 2'd0 && dmw1.plv0) || (plv == 2'd3 && dmw1.plv3));

    assign tlb_paddr = (tlb_res.ps == 6'd22) ? {tlb_res.ppn[19:10], vaddr[21:0]}
                                             : {tlb_res.ppn, vaddr[11:0]};

    always_comb begin
        if (direct_mode)
            paddr = vaddr;
        else if (dmw0_hit)
            paddr = {dmw0.pseg, vaddr[28:0]};   // dmw0 has priority
        else if (dmw1_hit)
            paddr = {dmw1.pseg, vaddr[28:0]};
        else
            paddr = tlb_paddr;
    end

    assign tlb_used = ~direct_mode & ~dmw0_hit & ~dmw1_hit;

    // tlbr, then pif, then ppi
    assign tlb_exc[`EARRAY_TLBR_FETCH] = tlb_used & ~tlb_res.found;
    assign tlb_exc[`EARRAY_PIF]        = tlb_used & tlb_res.found & ~tlb_res.v;
    assign tlb_exc[`EARRAY_PPI_FETCH]  = tlb_used & tlb_res.found & tlb_res.v &
                                         (plv > tlb_res.plv);

    assign tlb_exc[`EARRAY_PIL]      = 1'b0;
    assign tlb_exc[`EARRAY_PIS]      = 1'b0;
    assign tlb_exc[`EARRAY_PME]      = 1'b0;
    assign tlb_exc[`EARRAY_TLBR_MEM] = 1'b0;
    assign tlb_exc[`EARRAY_PPI_MEM]  = 1'b0;

endmodule

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none

`include "loongarch_fetch_macros.svh"

package fetch_pkg;

    // branch result from decode/execute
    typedef struct packed {
        logic        stall;        // branch not resolved yet
        logic        taken;
        logic [31:0] target;
    } br_req_t;

    // one instruction handed to decode
    typedef struct packed {
        logic [`TLB_ERRLEN-1:0] tlb_exc;
        logic [31:0]            inst;
        logic [31:0]            pc;
        logic                   adef;
    } fs2ds_t;

    // one direct-mapped window
    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_cfg_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vppn;         // va[31:13]
        logic [5:0]  ps;           // 12 or 22
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_entry_t;

    typedef struct packed {
        logic                        found;
        logic [$clog2(`TLBNUM)-1:0]  index;
        logic [19:0]                 ppn;
        logic [5:0]                  ps;
        logic [1:0]                  plv;
        logic [1:0]                  mat;
        logic                        d;
        logic                        v;
    } tlb_result_t;

    // exception entry and ertn return
    typedef struct packed {
        logic        wb_ex;
        logic        ertn_flush;
        logic [31:0] ex_entry;
        logic [31:0] ertn_entry;
    } redirect_t;

endpackage

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "loongarch_fetch_macros.svh"

module fetch_stage import fetch_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    resetn,
    // instruction sram
    output logic                         inst_sram_req,
    output logic [31:0]                  inst_sram_addr,
    input  wire logic                    inst_sram_addr_ok,
    input  wire logic                    inst_sram_data_ok,
    input  wire logic [31:0]             inst_sram_rdata,
    // redirects
    input  br_req_t                      br,
    input  redirect_t                    redir,
    // translation
    output logic [31:0]                  nextpc_vrtl,
    input  wire logic [31:0]             paddr,
    input  wire logic [`TLB_ERRLEN-1:0]  tlb_exc_raw,
    // to decode
    input  wire logic                    ds_allowin,
    output logic                         fs2ds_valid,
    output fs2ds_t                       fs2ds_bus
);

    logic        fs_valid;
    logic        fs_ready_go;
    logic        fs_allowin;
    logic        fs_cancel;
    logic        pf_ready_go;
    logic [31:0] fs_pc;
    logic [31:0] seq_pc;

    logic        inst_sram_addr_ack;   // accepted, response still owed
    logic        pf_block;
    logic        inst_discard;

    logic        fs_inst_buf_valid;
    logic [31:0] fs_inst_buf;
    logic [31:0] fs_inst;

    logic                   fs_adef;
    logic [`TLB_ERRLEN-1:0] fs_tlb_exc;

    // redirects that missed their accept cycle
    logic        ex_r;
    logic        ertn_r;
    logic        br_r;
    logic [31:0] ex_entry_r;
    logic [31:0] ertn_entry_r;
    logic [31:0] br_target_r;

    assign fs_cancel = redir.wb_ex | redir.ertn_flush | br.taken;
    assign seq_pc    = fs_pc + 32'd4;

    always_comb begin
        if (redir.wb_ex)           nextpc_vrtl = redir.ex_entry;
        else if (ex_r)             nextpc_vrtl = ex_entry_r;
        else if (redir.ertn_flush) nextpc_vrtl = redir.ertn_entry;
        else if (ertn_r)           nextpc_vrtl = ertn_entry_r;
        else if (br.taken)         nextpc_vrtl = br.target;
        else if (br_r)             nextpc_vrtl = br_target_r;
        else                       nextpc_vrtl = seq_pc;
    end

    // pre-IF
    assign inst_sram_req  = fs_allowin & ~inst_sram_addr_ack & ~pf_block &
                            (~br.stall | redir.wb_ex | redir.ertn_flush);
    assign inst_sram_addr = paddr;
    assign pf_ready_go    = inst_sram_req & inst_sram_addr_ok;

    always_ff @(posedge clk) begin
        if (~resetn) begin
            ex_r   <= 1'b0;
            ertn_r <= 1'b0;
            br_r   <= 1'b0;
        end else if (pf_ready_go) begin
            ex_r   <= 1'b0;   // target went out with this request
            ertn_r <= 1'b0;
            br_r   <= 1'b0;
        end else begin
            if (redir.wb_ex)      ex_r   <= 1'b1;
            if (redir.ertn_flush) ertn_r <= 1'b1;
            if (br.taken)         br_r   <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redir.wb_ex)      ex_entry_r   <= redir.ex_entry;
        if (redir.ertn_flush) ertn_entry_r <= redir.ertn_entry;
        if (br.taken)         br_target_r  <= br.target;
    end

    always_ff @(posedge clk) begin
        if (~resetn)
            inst_sram_addr_ack <= 1'b0;
        else if (pf_ready_go)
            inst_sram_addr_ack <= 1'b1;
        else if (inst_sram_data_ok)
            inst_sram_addr_ack <= 1'b0;
    end

    // held through reset, and while a cancelled response is on its way
    always_ff @(posedge clk) begin
        if (~resetn)
            pf_block <= 1'b1;
        else if (fs_cancel & inst_sram_addr_ack & ~inst_sram_data_ok)
            pf_block <= 1'b1;
        else if (inst_sram_data_ok | ~inst_sram_addr_ack)
            pf_block <= 1'b0;
    end

    assign inst_discard = pf_block & inst_sram_addr_ack;   // next data_ok is stale

    // IF
    assign fs_ready_go = (inst_sram_data_ok & ~inst_discard) | fs_inst_buf_valid;
    assign fs_allowin  = ~fs_valid | (fs_ready_go & ds_allowin) | fs_cancel;
    assign fs2ds_valid = fs_valid & fs_ready_go & ~fs_cancel;

    always_ff @(posedge clk) begin
        if (~resetn)
            fs_valid <= 1'b0;
        else if (fs_allowin)
            fs_valid <= pf_ready_go;
    end

    always_ff @(posedge clk) begin
        if (~resetn) begin
            fs_pc      <= `RESET_PC;
            fs_adef    <= 1'b0;
            fs_tlb_exc <= '0;
        end else if (pf_ready_go) begin
            fs_pc      <= nextpc_vrtl;
            fs_adef    <= |nextpc_vrtl[1:0];
            fs_tlb_exc <= tlb_exc_raw;
        end
    end

    // hold the returned word while decode is stalled
    always_ff @(posedge clk) begin
        if (~resetn)
            fs_inst_buf_valid <= 1'b0;
        else if (fs_cancel | (fs_ready_go & ds_allowin))
            fs_inst_buf_valid <= 1'b0;
        else if (inst_sram_data_ok & ~inst_discard)
            fs_inst_buf_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (inst_sram_data_ok & ~fs_inst_buf_valid)
            fs_inst_buf <= inst_sram_rdata;
    end

    assign fs_inst = fs_inst_buf_valid ? fs_inst_buf : inst_sram_rdata;

    assign fs2ds_bus.tlb_exc = fs_tlb_exc & {`TLB_ERRLEN{fs_valid}};
    assign fs2ds_bus.inst    = fs_inst;
    assign fs2ds_bus.pc      = fs_pc;
    assign fs2ds_bus.adef    = fs_adef & fs_valid;

endmodule

`default_nettype wire

/* loongarch_fetch.f */
+incdir+.
fetch_pkg.sv
tlb_lookup.sv
addr_translate.sv
fetch_stage.sv
loongarch_fetch.sv
loongarch_fetch_properties.sv
loongarch_fetch_tb.sv

/* loongarch_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "loongarch_fetch_macros.svh"

module loongarch_fetch import fetch_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        resetn,
    // instruction sram
    output logic                             inst_sram_req,
    output logic [31:0]                      inst_sram_addr,
    input  wire logic                        inst_sram_addr_ok,
    input  wire logic                        inst_sram_data_ok,
    input  wire logic [31:0]                 inst_sram_rdata,
    // pipeline
    input  wire logic                        ds_allowin,
    input  br_req_t                          br,
    input  redirect_t                        redir,
    output logic                             fs2ds_valid,
    output fs2ds_t                           fs2ds_bus,
    // csr state
    input  wire logic                        csr_direct_addr,
    input  wire logic [1:0]                  crmd_plv,
    input  dmw_cfg_t                         dmw0,
    input  dmw_cfg_t                         dmw1,
    // tlb fill
    input  wire logic                        tlb_we,
    input  wire logic [$clog2(`TLBNUM)-1:0]  tlb_w_index,
    input  tlb_entry_t                       tlb_w_entry
);

    logic [31:0]            nextpc_vrtl;
    logic [31:0]            paddr;
    logic [`TLB_ERRLEN-1:0] tlb_exc_raw;
    logic [18:0]            s0_vppn;
    logic                   s0_va_bit12;
    tlb_result_t            s0_result;

    fetch_stage i_fetch_stage (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .br                (br),
        .redir             (redir),
        .nextpc_vrtl       (nextpc_vrtl),
        .paddr             (paddr),
        .tlb_exc_raw       (tlb_exc_raw),
        .ds_allowin        (ds_allowin),
        .fs2ds_valid       (fs2ds_valid),
        .fs2ds_bus         (fs2ds_bus)
    );

    addr_translate i_addr_translate (
        .vaddr       (nextpc_vrtl),
        .direct_mode (csr_direct_addr),
        .plv         (crmd_plv),
        .dmw0        (dmw0),
        .dmw1        (dmw1),
        .vppn        (s0_vppn),
        .va_bit12    (s0_va_bit12),
        .tlb_res     (s0_result),
        .paddr       (paddr),
        .tlb_exc     (tlb_exc_raw)
    );

    tlb_lookup i_tlb_lookup (
        .clk         (clk),
        .resetn      (resetn),
        .s0_vppn     (s0_vppn),
        .s0_va_bit12 (s0_va_bit12),
        .s0_result   (s0_result),
        .we          (tlb_we),
        .w_index     (tlb_w_index),
        .w_entry     (tlb_w_entry)
    );

endmodule

`default_nettype wire

/* loongarch_fetch_macros.svh */
`ifndef LOONGARCH_FETCH_MACROS_SVH
`define LOONGARCH_FETCH_MACROS_SVH

// tlb geometry
`define TLBNUM              16

// fs_pc reset value, first fetch lands on 0x1c000000
`define RESET_PC            32'h1BFF_FFFC

// exception vector carried with each fetched instruction
`define TLB_ERRLEN          8

// fetch side
`define EARRAY_TLBR_FETCH   0
`define EARRAY_PIF          1
`define EARRAY_PPI_FETCH    2

// data side, always zero in the fetch stage
`define EARRAY_PIL          3
`define EARRAY_PIS          4
`define EARRAY_PME          5
`define EARRAY_TLBR_MEM     6
`define EARRAY_PPI_MEM      7

`endif

/* loongarch_fetch_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module loongarch_fetch_properties import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire logic        resetn,
    input  wire logic        inst_sram_req,
    input  wire logic [31:0] inst_sram_addr,
    input  wire logic        inst_sram_addr_ok,
    input  wire logic        inst_sram_data_ok,
    input  wire logic        ds_allowin,
    input  br_req_t          br,
    input  redirect_t        redir,
    input  wire logic        fs2ds_valid,
    input  fs2ds_t           fs2ds_bus
);

    logic owed;     // accepted request without its data_ok yet
    logic cancel;

    assign cancel = redir.wb_ex | redir.ertn_flush | br.taken;

    always_ff @(posedge clk) begin
        if (~resetn)
            owed <= 1'b0;
        else if (inst_sram_req && inst_sram_addr_ok)
            owed <= 1'b1;
        else if (inst_sram_data_ok)
            owed <= 1'b0;
    end

    quiet_in_reset: assert property (@(posedge clk)
        !resetn && $past(!resetn) |-> !inst_sram_req && !fs2ds_valid &&
        fs2ds_bus.tlb_exc == '0 && !fs2ds_bus.adef)
        else $error("request, valid or exception bits active during reset");

    single_outstanding: assert property (@(posedge clk) disable iff (!resetn)
        owed |-> !(inst_sram_req && inst_sram_addr_ok))
        else $error("second request accepted before data_ok");

    // address may only move on a redirect
    addr_held: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_req && !inst_sram_addr_ok |=>
        inst_sram_req && (cancel || $stable(inst_sram_addr)))
        else $error("sram request dropped or address changed while waiting for addr_ok");

    bus_held: assert property (@(posedge clk) disable iff (!resetn)
        fs2ds_valid && !ds_allowin |=> cancel || (fs2ds_valid && $stable(fs2ds_bus)))
        else $error("fetch output changed or dropped under back-pressure");

endmodule

`default_nettype wire

/* loongarch_fetch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "loongarch_fetch_macros.svh"

module loongarch_fetch_tb import fetch_pkg::*; ();

    logic                       clk;
    logic                       resetn;
    logic                       inst_sram_req;
    logic [31:0]                inst_sram_addr;
    logic                       addr_ok = 1'b0;
    logic                       data_ok = 1'b0;
    logic [31:0]                rdata = 32'h0;
    logic                       ds_allowin = 1'b0;
    br_req_t                    br;
    redirect_t                  redir;
    logic                       fs2ds_valid;
    fs2ds_t                     fs2ds_bus;
    logic                       direct;
    logic [1:0]                 plv;
    dmw_cfg_t                   dmw0;
    dmw_cfg_t                   dmw1;
    logic                       tlb_we;
    logic [$clog2(`TLBNUM)-1:0] tlb_w_index;
    tlb_entry_t                 tlb_w_entry;

    tlb_entry_t  ref_tlb [`TLBNUM];
    logic [31:0] redirect_q [$];   // targets of pulses not yet delivered
    logic [31:0] exp_pc = 32'h1C00_0000;
    logic [31:0] rng_state = 32'd41;
    int          delivered = 0;
    int          cycles = 0;

    // sram model state
    int          acc_wait = 0;
    int          resp_wait = 0;
    logic        resp_pend = 1'b0;
    logic [31:0] resp_addr = 32'h0;

    loongarch_fetch i_loongarch_fetch (
        .clk (clk), .resetn (resetn),
        .inst_sram_req (inst_sram_req), .inst_sram_addr (inst_sram_addr),
        .inst_sram_addr_ok (addr_ok), .inst_sram_data_ok (data_ok),
        .inst_sram_rdata (rdata), .ds_allowin (ds_allowin),
        .br (br), .redir (redir),
        .fs2ds_valid (fs2ds_valid), .fs2ds_bus (fs2ds_bus),
        .csr_direct_addr (direct), .crmd_plv (plv), .dmw0 (dmw0), .dmw1 (dmw1),
        .tlb_we (tlb_we), .tlb_w_index (tlb_w_index), .tlb_w_entry (tlb_w_entry)
    );

    bind loongarch_fetch loongarch_fetch_properties i_properties (
        .clk (clk), .resetn (resetn),
        .inst_sram_req (inst_sram_req), .inst_sram_addr (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok), .inst_sram_data_ok (inst_sram_data_ok),
        .ds_allowin (ds_allowin), .br (br), .redir (redir),
        .fs2ds_valid (fs2ds_valid), .fs2ds_bus (fs2ds_bus)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic dmw_hit(input dmw_cfg_t cfg, input logic [31:0] va);
        return va[31:29] == cfg.vseg &&
               ((plv == 2'd0 && cfg.plv0) || (plv == 2'd3 && cfg.plv3));
    endfunction

    // lowest valid matching entry, -1 on miss
    function automatic int tlb_match(input logic [31:0] va);
        for (int i = 0; i < `TLBNUM; i++) begin
            if (ref_tlb[i].e && ref_tlb[i].ps == 6'd22 && ref_tlb[i].vppn[18:9] == va[31:22])
                return i;
            if (ref_tlb[i].e && ref_tlb[i].ps == 6'd12 && ref_tlb[i].vppn == va[31:13])
                return i;
        end
        return -1;
    endfunction

    function automatic logic [31:0] ref_paddr(input logic [31:0] va);
        tlb_entry_t ent;
        int         idx;
        if (direct)
            return va;
        if (dmw_hit(dmw0, va))
            return {dmw0.pseg, va[28:0]};
        if (dmw_hit(dmw1, va))
            return {dmw1.pseg, va[28:0]};
        idx = tlb_match(va);
        ent = ref_tlb[idx];
        if (ent.ps == 6'd22)
            return {ent.ppn[19:10], va[21:0]};
        return {ent.ppn[19:1], va[12], va[11:0]};   // even/odd half by va bit 12
    endfunction

    function automatic logic [`TLB_ERRLEN-1:0] ref_exc(input logic [31:0] va);
        logic [`TLB_ERRLEN-1:0] exc;
        int                     idx;
        exc = '0;
        if (direct || dmw_hit(dmw0, va) || dmw_hit(dmw1, va))
            return exc;
        idx = tlb_match(va);
        if (idx < 0)
            exc[`EARRAY_TLBR_FETCH] = 1'b1;
        else if (!ref_tlb[idx].v)
            exc[`EARRAY_PIF] = 1'b1;
        else if (plv > ref_tlb[idx].plv)
            exc[`EARRAY_PPI_FETCH] = 1'b1;
        return exc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // accept capture, delivery check and run limit
    always @(posedge clk) begin
        logic [`TLB_ERRLEN-1:0] exc;
        cycles = cycles + 1;
        if (cycles >= 3000) begin
            $display("timeout: run did not finish within 3000 cycles");
            $display("Verification failed");
            $fatal(1, "timeout");
        end
        if (resetn && inst_sram_req && addr_ok) begin
            resp_pend = 1'b1;
            resp_addr = inst_sram_addr;
            resp_wait = 1 + int'(next_rand() % 4);
            acc_wait  = int'(next_rand() % 4);
        end
        if (resetn && fs2ds_valid && ds_allowin) begin
            if (redirect_q.size() > 0) begin
                exp_pc = redirect_q[$];
                redirect_q.delete();
            end
            exc = ref_exc(exp_pc);
            check_value("fs2ds_bus.pc", fs2ds_bus.pc, exp_pc);
            check_value("fs2ds_bus.tlb_exc", 32'(fs2ds_bus.tlb_exc), 32'(exc));
            check_value("fs2ds_bus.adef", 32'(fs2ds_bus.adef), 32'(|exp_pc[1:0]));
            if (exc == '0)
                check_value("fs2ds_bus.inst", fs2ds_bus.inst,
                            ref_paddr(exp_pc) ^ 32'hA5A5_0000);
            exp_pc    = exp_pc + 32'd4;
            delivered = delivered + 1;
        end
    end

    // sram responses and decode back-pressure
    always @(negedge clk) begin
        if (!resetn) begin
            addr_ok    = 1'b0;
            data_ok    = 1'b0;
            ds_allowin = 1'b0;
        end else begin
            data_ok = 1'b0;
            if (resp_pend) begin
                if (resp_wait == 1) begin
                    data_ok   = 1'b1;
                    rdata     = resp_addr ^ 32'hA5A5_0000;
                    resp_pend = 1'b0;
                end else begin
                    resp_wait = resp_wait - 1;
                end
            end
            if (acc_wait > 0 && inst_sram_req)
                acc_wait = acc_wait - 1;
            addr_ok    = (acc_wait == 0);
            ds_allowin = (next_rand() % 4) != 0;
        end
    end

    task automatic wait_deliveries(input int n);
        int target;
        target = delivered + n;
        wait (delivered >= target);
        @(negedge clk);
    endtask

    // one-cycle redirect, called at a falling edge
    task automatic pulse(input logic ex, input logic er, input logic bt,
                         input logic [31:0] t_ex, input logic [31:0] t_er,
                         input logic [31:0] t_br);
        redir.wb_ex      = ex;
        redir.ex_entry   = t_ex;
        redir.ertn_flush = er;
        redir.ertn_entry = t_er;
        br.taken         = bt;
        br.target        = t_br;
        if (ex)
            redirect_q.push_back(t_ex);
        else if (er)
            redirect_q.push_back(t_er);
        else if (bt)
            redirect_q.push_back(t_br);
        @(negedge clk);
        redir.wb_ex      = 1'b0;
        redir.ertn_flush = 1'b0;
        br.taken         = 1'b0;
    endtask

    task automatic jump(input logic [31:0] target);
        pulse(1'b0, 1'b0, 1'b1, 32'h0, 32'h0, target);
    endtask

    task automatic fill_tlb(input logic [3:0] idx, input logic [18:0] vppn,
                            input logic [5:0] ps, input logic [19:0] ppn,
                            input logic [1:0] ent_plv, input logic v);
        tlb_entry_t ent;
        ent          = '0;
        ent.e        = 1'b1;
        ent.vppn     = vppn;
        ent.ps       = ps;
        ent.ppn      = ppn;
        ent.plv      = ent_plv;
        ent.mat      = 2'd1;
        ent.v        = v;
        tlb_we       = 1'b1;
        tlb_w_index  = idx;
        tlb_w_entry  = ent;
        ref_tlb[idx] = ent;
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        resetn      = 1'b0;
        br          = '0;
        redir       = '0;
        direct      = 1'b1;
        plv         = 2'd0;
        dmw0        = '0;
        dmw1        = '0;
        tlb_we      = 1'b0;
        tlb_w_index = '0;
        tlb_w_entry = '0;
        for (int i = 0; i < `TLBNUM; i++)
            ref_tlb[i] = '0;
        repeat (8) @(negedge clk);
        resetn = 1'b1;

        // fills land while still in direct mode
        fill_tlb(4'd0, 19'h00200, 6'd12, 20'h12340, 2'd3, 1'b1);  // 4k pair at 0x00400000
        fill_tlb(4'd1, 19'h04000, 6'd22, 20'h30000, 2'd3, 1'b1);  // 4m at 0x08000000
        fill_tlb(4'd2, 19'h00800, 6'd12, 20'h45600, 2'd3, 1'b0);  // invalid page
        fill_tlb(4'd3, 19'h01000, 6'd12, 20'h78900, 2'd0, 1'b1);  // kernel only
        wait_deliveries(40);

        // windows, config switches together with the jump
        direct    = 1'b0;
        dmw0.plv0 = 1'b1;
        dmw0.vseg = 3'd5;
        dmw0.pseg = 3'd0;
        dmw1.plv0 = 1'b1;
        dmw1.plv3 = 1'b1;
        dmw1.vseg = 3'd4;
        dmw1.pseg = 3'd1;
        jump(32'hA000_0000);
        wait_deliveries(30);
        jump(32'h8000_1000);
        wait_deliveries(30);

        plv = 2'd3;
        jump(32'h0040_0FC0);    // runs across the odd half of the pair
        wait_deliveries(30);
        jump(32'h0812_3400);
        wait_deliveries(20);
        jump(32'h0300_0000);    // unmapped
        wait_deliveries(5);
        jump(32'h0100_0000);
        wait_deliveries(5);
        jump(32'h0200_0000);
        wait_deliveries(5);
        jump(32'h0812_0002);    // misaligned
        wait_deliveries(5);

        // mixed redirects inside the 4m page
        for (int i = 0; i < 20; i++) begin
            r = next_rand();
            if (r[2:0] == 3'b000)
                r[0] = 1'b1;
            pulse(r[2], r[1], r[0],
                  32'h0800_0000 | (next_rand() & 32'h003F_FFFC),
                  32'h0800_0000 | (next_rand() & 32'h003F_FFFC),
                  32'h0800_0000 | (next_rand() & 32'h003F_FFFC));
            wait_deliveries(1 + int'(r[4:3]));
        end
        wait_deliveries(3);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f loongarch_fetch.f \
    --top-module loongarch_fetch_tb \
    -o loongarch_fetch_sim \
    && ./obj_dir/loongarch_fetch_sim \
    || exit 1

/* tlb_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

`include "loongarch_fetch_macros.svh"

module tlb_lookup import fetch_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        resetn,
    // search port
    input  wire logic [18:0]                 s0_vppn,
    input  wire logic                        s0_va_bit12,
    output tlb_result_t                      s0_result,
    // fill port
    input  wire logic                        we,
    input  wire logic [$clog2(`TLBNUM)-1:0]  w_index,
    input  tlb_entry_t                       w_entry
);

    localparam int IDXW = $clog2(`TLBNUM);

    tlb_entry_t         tlb_mem [`TLBNUM];
    logic [`TLBNUM-1:0] match;
    logic [IDXW-1:0]    hit_idx;
    logic               hit;
    tlb_entry_t         hit_entry;

    // entries come up invalid
    always_ff @(posedge clk) begin
        if (~resetn) begin
            for (int i = 0; i < `TLBNUM; i++) begin
                tlb_mem[i].e <= 1'b0;
            end
        end else if (we) begin
            tlb_mem[w_index] <= w_entry;
        end
    end

    // 4M pages compare va[31:22] only
    always_comb begin
        for (int i = 0; i < `TLBNUM; i++) begin
            if (tlb_mem[i].ps == 6'd22)
                match[i] = tlb_mem[i].e && (tlb_mem[i].vppn[18:9] == s0_vppn[18:9]);
            else
                match[i] = tlb_mem[i].e && (tlb_mem[i].vppn == s0_vppn);
        end
    end

    // walk downwards so the lowest matching index is the last one written
    always_comb begin
        hit_idx = '0;
        hit     = 1'b0;
        for (int i = `TLBNUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = IDXW'(i);
                hit     = 1'b1;
            end
        end
    end

    assign hit_entry = tlb_mem[hit_idx];

    assign s0_result.found = hit;
    assign s0_result.index = hit_idx;
    // bit 12 picks the half of a 4k page pair
    assign s0_result.ppn   = (hit_entry.ps == 6'd12) ? {hit_entry.ppn[19:1], s0_va_bit12}
                                                     : hit_entry.ppn;
    assign s0_result.ps    = hit_entry.ps;
    assign s0_result.plv   = hit_entry.plv;
    assign s0_result.mat   = hit_entry.mat;
    assign s0_result.d     = hit_entry.d;
    assign s0_result.v     = hit_entry.v;

endmodule

`default_nettype wire
